//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = cdb_tb
FILELIST = compile.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep "Test passed" > /dev/null

clean:
	rm -rf $(BUILD)

//--- cdb.sv
`include "cdb_macros.svh"

module cdb (
    input  logic                  clock,
    input  logic                  rst_n,
    input  logic                  commit_mis_pred,

    input  logic                  alu_valid,
    input  logic [`XLEN-1:0]      alu_value,
    input  logic [`PRF_LEN-1:0]   alu_prf_idx,
    input  logic [`ROB_LEN-1:0]   alu_rob_idx,
    input  logic [`XLEN-1:0]      alu_pc,

    input  logic                  mul_valid,
    input  logic [`XLEN-1:0]      mul_value,
    input  logic [`PRF_LEN-1:0]   mul_prf_idx,
    input  logic [`ROB_LEN-1:0]   mul_rob_idx,
    input  logic [`XLEN-1:0]      mul_pc,

    input  logic                  br_valid,
    input  logic [`XLEN-1:0]      br_value,
    input  logic [`PRF_LEN-1:0]   br_prf_idx,
    input  logic [`ROB_LEN-1:0]   br_rob_idx,
    input  logic [`XLEN-1:0]      br_pc,
    input  logic                  br_direction,
    input  logic [`XLEN-1:0]      br_target_pc,
    input  logic                  br_mis_pred,
    input  logic                  br_local_pred,
    input  logic                  br_global_pred,

    input  logic                  dcache_valid,
    input  logic [`XLEN-1:0]      dcache_value,
    input  logic [`PRF_LEN-1:0]   dcache_prf_idx,
    input  logic [`ROB_LEN-1:0]   dcache_rob_idx,
    input  logic [`XLEN-1:0]      dcache_pc,

    input  logic                  sq_valid,
    input  logic [`XLEN-1:0]      sq_value,
    input  logic [`PRF_LEN-1:0]   sq_prf_idx,
    input  logic [`ROB_LEN-1:0]   sq_rob_idx,
    input  logic [`XLEN-1:0]      sq_pc,

    output cdb_pkg::cdb_src_e     module_select,
    output logic                  cdb_valid,
    output logic [`XLEN-1:0]      cdb_value,
    output logic [`PRF_LEN-1:0]   cdb_prf_idx,
    output logic [`ROB_LEN-1:0]   cdb_rob_idx,
    output logic [`XLEN-1:0]      cdb_pc,
    output logic                  cdb_br_direction,
    output logic [`XLEN-1:0]      cdb_br_target_pc,
    output logic                  cdb_mis_pred,
    output logic                  cdb_local_pred,
    output logic                  cdb_global_pred
);

    // request and grant, bit 4 alu down to bit 0 store queue
    logic [4:0] request;
    logic [4:0] grant;

    logic [`CDB_PAYLOAD_W-1:0]    alu_head;
    logic [`CDB_PAYLOAD_W-1:0]    mul_head;
    logic [`CDB_BR_PAYLOAD_W-1:0] br_head;
    logic [`CDB_PAYLOAD_W-1:0]    dcache_head;
    logic [`CDB_PAYLOAD_W-1:0]    sq_head;

    // occupancy flags, watched by the bound checker
    logic alu_full;
    logic mul_full;
    logic br_full;
    logic dcache_full;
    logic sq_full;

    result_queue #(.DEPTH(`ALU_QUEUE_SIZE), .WIDTH(`CDB_PAYLOAD_W)) alu_queue (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (commit_mis_pred),
        .push      (alu_valid),
        .pop       (grant[4]),
        .data_in   ({alu_value, alu_prf_idx, alu_rob_idx, alu_pc}),
        .request   (request[4]),
        .head_data (alu_head),
        .full      (alu_full)
    );

    result_queue #(.DEPTH(`MUL_QUEUE_SIZE), .WIDTH(`CDB_PAYLOAD_W)) mul_queue (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (commit_mis_pred),
        .push      (mul_valid),
        .pop       (grant[3]),
        .data_in   ({mul_value, mul_prf_idx, mul_rob_idx, mul_pc}),
        .request   (request[3]),
        .head_data (mul_head),
        .full      (mul_full)
    );

    // branch entries carry the resolution and predictor bits behind the common fields
    result_queue #(.DEPTH(`BR_QUEUE_SIZE), .WIDTH(`CDB_BR_PAYLOAD_W)) br_queue (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (commit_mis_pred),
        .push      (br_valid),
        .pop       (grant[2]),
        .data_in   ({br_value, br_prf_idx, br_rob_idx, br_pc, br_direction,
                     br_target_pc, br_mis_pred, br_local_pred, br_global_pred}),
        .request   (request[2]),
        .head_data (br_head),
        .full      (br_full)
    );

    result_queue #(.DEPTH(`DCACHE_QUEUE_SIZE), .WIDTH(`CDB_PAYLOAD_W)) dcache_queue (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (commit_mis_pred),
        .push      (dcache_valid),
        .pop       (grant[1]),
        .data_in   ({dcache_value, dcache_prf_idx, dcache_rob_idx, dcache_pc}),
        .request   (request[1]),
        .head_data (dcache_head),
        .full      (dcache_full)
    );

    result_queue #(.DEPTH(`SQ_QUEUE_SIZE), .WIDTH(`CDB_PAYLOAD_W)) sq_queue (
        .clock     (clock),
        .rst_n     (rst_n),
        .flush     (commit_mis_pred),
        .push      (sq_valid),
        .pop       (grant[0]),
        .data_in   ({sq_value, sq_prf_idx, sq_rob_idx, sq_pc}),
        .request   (request[0]),
        .head_data (sq_head),
        .full      (sq_full)
    );

    cdb_arbiter arbiter (
        .request (request),
        .grant   (grant),
        .source  (module_select)
    );

    cdb_broadcast_mux broadcast_mux (
        .source           (module_select),
        .alu_head         (alu_head),
        .mul_head         (mul_head),
        .br_head          (br_head),
        .dcache_head      (dcache_head),
        .sq_head          (sq_head),
        .cdb_valid        (cdb_valid),
        .cdb_value        (cdb_value),
        .cdb_prf_idx      (cdb_prf_idx),
        .cdb_rob_idx      (cdb_rob_idx),
        .cdb_pc           (cdb_pc),
        .cdb_br_direction (cdb_br_direction),
        .cdb_br_target_pc (cdb_br_target_pc),
        .cdb_mis_pred     (cdb_mis_pred),
        .cdb_local_pred   (cdb_local_pred),
        .cdb_global_pred  (cdb_global_pred)
    );

endmodule

//--- cdb_arbiter.sv
module cdb_arbiter (
    input  logic [4:0]        request,
    output logic [4:0]        grant,
    output cdb_pkg::cdb_src_e source
);

    import cdb_pkg::*;

    // bit 4 is alu, bit 0 is store queue
    always_comb begin
        grant  = 5'b00000;
        source = SRC_NONE;
        if (request[4]) begin
            grant[4] = 1'b1;
            source   = SRC_ALU;
        end else if (request[3]) begin
            grant[3] = 1'b1;
            source   = SRC_MUL;
        end else if (request[2]) begin
            grant[2] = 1'b1;
            source   = SRC_BR;
        end else if (request[1]) begin
            grant[1] = 1'b1;
            source   = SRC_DCACHE;
        end else if (request[0]) begin
            grant[0] = 1'b1;
            source   = SRC_SQ;
        end
    end

endmodule

//--- cdb_broadcast_mux.sv
`include "cdb_macros.svh"

module cdb_broadcast_mux (
    input  cdb_pkg::cdb_src_e            source,
    input  logic [`CDB_PAYLOAD_W-1:0]    alu_head,
    input  logic [`CDB_PAYLOAD_W-1:0]    mul_head,
    input  logic [`CDB_BR_PAYLOAD_W-1:0] br_head,
    input  logic [`CDB_PAYLOAD_W-1:0]    dcache_head,
    input  logic [`CDB_PAYLOAD_W-1:0]    sq_head,
    output logic                         cdb_valid,
    output logic [`XLEN-1:0]             cdb_value,
    output logic [`PRF_LEN-1:0]          cdb_prf_idx,
    output logic [`ROB_LEN-1:0]          cdb_rob_idx,
    output logic [`XLEN-1:0]             cdb_pc,
    output logic                         cdb_br_direction,
    output logic [`XLEN-1:0]             cdb_br_target_pc,
    output logic                         cdb_mis_pred,
    output logic                         cdb_local_pred,
    output logic                         cdb_global_pred
);

    import cdb_pkg::*;

    // common fields of the selected head
    logic [`CDB_PAYLOAD_W-1:0] common;

    always_comb begin
        cdb_valid        = 1'b1;
        cdb_br_direction = 1'b0;
        cdb_br_target_pc = `CDB_NO_TARGET;
        cdb_mis_pred     = 1'b0;
        cdb_local_pred   = 1'b0;
        cdb_global_pred  = 1'b0;
        case (source)
            SRC_ALU: begin
                common = alu_head;
            end
            SRC_MUL: begin
                common = mul_head;
            end
            SRC_BR: begin
                {common, cdb_br_direction, cdb_br_target_pc, cdb_mis_pred,
                 cdb_local_pred, cdb_global_pred} = br_head;
            end
            SRC_DCACHE: begin
                common = dcache_head;
            end
            SRC_SQ: begin
                common = sq_head;
            end
            default: begin
                // idle bus, only the pc carries the marker value
                cdb_valid = 1'b0;
                common    = {{(`XLEN + `PRF_LEN + `ROB_LEN){1'b0}}, `CDB_NO_TARGET};
            end
        endcase
        {cdb_value, cdb_prf_idx, cdb_rob_idx, cdb_pc} = common;
    end

endmodule

//--- cdb_checker.sv
`include "cdb_macros.svh"

module cdb_checker (
    input logic                 clock,
    input logic                 rst_n,
    input logic                 commit_mis_pred,
    input logic                 alu_valid,
    input logic                 mul_valid,
    input logic                 br_valid,
    input logic                 dcache_valid,
    input logic                 sq_valid,
    input logic                 alu_full,
    input logic                 mul_full,
    input logic                 br_full,
    input logic                 dcache_full,
    input logic                 sq_full,
    input logic [4:0]           grant,
    input cdb_pkg::cdb_src_e    module_select,
    input logic                 cdb_valid,
    input logic                 cdb_br_direction,
    input logic [`XLEN-1:0]     cdb_br_target_pc,
    input logic                 cdb_mis_pred,
    input logic                 cdb_local_pred,
    input logic                 cdb_global_pred
);

    timeunit 1ns;
    timeprecision 100ps;

    import cdb_pkg::*;

    int unsigned failures = 0;

    logic       any_valid;
    logic [4:0] overrun;

    assign any_valid = alu_valid | mul_valid | br_valid | dcache_valid | sq_valid;

    // a push into a full queue is only safe when the head leaves in the same edge
    assign overrun = {alu_full & alu_valid & ~grant[4],
                      mul_full & mul_valid & ~grant[3],
                      br_full & br_valid & ~grant[2],
                      dcache_full & dcache_valid & ~grant[1],
                      sq_full & sq_valid & ~grant[0]};

    valid_matches_select: assert property (@(posedge clock) disable iff (!rst_n)
        cdb_valid == (module_select != SRC_NONE))
    else begin
        $error("cdb_valid disagrees with module_select");
        failures++;
    end

    branch_defaults: assert property (@(posedge clock) disable iff (!rst_n)
        (module_select != SRC_BR) |-> (!cdb_br_direction && !cdb_mis_pred &&
            !cdb_local_pred && !cdb_global_pred && cdb_br_target_pc == `CDB_NO_TARGET))
    else begin
        $error("branch fields not at their defaults for a non-branch source");
        failures++;
    end

    no_overrun: assert property (@(posedge clock) disable iff (!rst_n)
        overrun == 5'b00000)
    else begin
        $error("result queue pushed while full without a pop");
        failures++;
    end

    // nothing survives a flush
    quiet_after_flush: assert property (@(posedge clock) disable iff (!rst_n)
        commit_mis_pred |=> (any_valid || !cdb_valid))
    else begin
        $error("bus still valid in the cycle after a flush");
        failures++;
    end

endmodule

bind cdb cdb_checker checker_inst (
    .clock            (clock),
    .rst_n            (rst_n),
    .commit_mis_pred  (commit_mis_pred),
    .alu_valid        (alu_valid),
    .mul_valid        (mul_valid),
    .br_valid         (br_valid),
    .dcache_valid     (dcache_valid),
    .sq_valid         (sq_valid),
    .alu_full         (alu_full),
    .mul_full         (mul_full),
    .br_full          (br_full),
    .dcache_full      (dcache_full),
    .sq_full          (sq_full),
    .grant            (grant),
    .module_select    (module_select),
    .cdb_valid        (cdb_valid),
    .cdb_br_direction (cdb_br_direction),
    .cdb_br_target_pc (cdb_br_target_pc),
    .cdb_mis_pred     (cdb_mis_pred),
    .cdb_local_pred   (cdb_local_pred),
    .cdb_global_pred  (cdb_global_pred)
);

//--- cdb_macros.svh
`ifndef CDB_MACROS_SVH
`define CDB_MACROS_SVH

// datapath widths
`define XLEN        32
`define PRF_LEN     6
`define ROB_LEN     5

// per-source result queue depths
`define ALU_QUEUE_SIZE      4
`define MUL_QUEUE_SIZE      4
`define BR_QUEUE_SIZE       4
`define DCACHE_QUEUE_SIZE   4
`define SQ_QUEUE_SIZE       4

// target pc shown on the bus when no branch is broadcast
`define CDB_NO_TARGET   32'hfacebeec

// queue payload: value, prf_idx, rob_idx, pc
`define CDB_PAYLOAD_W       (`XLEN + `PRF_LEN + `ROB_LEN + `XLEN)

// branch payload adds direction, target pc, mispredict and two predictor bits
`define CDB_BR_PAYLOAD_W    (`CDB_PAYLOAD_W + `XLEN + 4)

`endif

//--- cdb_pkg.sv
package cdb_pkg;

    // source currently driving the broadcast bus
    typedef enum logic [2:0] {
        SRC_NONE   = 3'd0,
        SRC_ALU    = 3'd1,
        SRC_MUL    = 3'd2,
        SRC_BR     = 3'd3,
        SRC_DCACHE = 3'd4,
        SRC_SQ     = 3'd5
    } cdb_src_e;

endpackage

//--- cdb_tb.sv
`include "cdb_macros.svh"

module cdb_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import cdb_pkg::*;

    localparam int BW = `CDB_BR_PAYLOAD_W;
    localparam int QDEPTH = 4;
    localparam logic [BW-1:0] IDLE_ENTRY = {{(`XLEN + `PRF_LEN + `ROB_LEN){1'b0}},
                                            `CDB_NO_TARGET, 1'b0, `CDB_NO_TARGET, 3'b000};

    logic clock;
    logic rst_n;
    logic commit_mis_pred;

    // index 0 alu, 1 mul, 2 branch, 3 dcache, 4 store queue
    logic                src_valid [5];
    logic [`XLEN-1:0]    src_value [5];
    logic [`PRF_LEN-1:0] src_prf [5];
    logic [`ROB_LEN-1:0] src_rob [5];
    logic [`XLEN-1:0]    src_pc [5];
    logic                br_direction;
    logic [`XLEN-1:0]    br_target_pc;
    logic                br_mis_pred;
    logic                br_local_pred;
    logic                br_global_pred;

    cdb_src_e            module_select;
    logic                cdb_valid;
    logic [`XLEN-1:0]    cdb_value;
    logic [`PRF_LEN-1:0] cdb_prf_idx;
    logic [`ROB_LEN-1:0] cdb_rob_idx;
    logic [`XLEN-1:0]    cdb_pc;
    logic                cdb_br_direction;
    logic [`XLEN-1:0]    cdb_br_target_pc;
    logic                cdb_mis_pred;
    logic                cdb_local_pred;
    logic                cdb_global_pred;

    // one reference queue per source
    logic [BW-1:0] model_q [5][$];

    int errors = 0;
    int timeouts = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_start = 0;
    int accepted = 0;
    int broadcasts = 0;

    cdb DUT (
        .clock (clock), .rst_n (rst_n), .commit_mis_pred (commit_mis_pred),
        .alu_valid (src_valid[0]), .alu_value (src_value[0]), .alu_prf_idx (src_prf[0]),
        .alu_rob_idx (src_rob[0]), .alu_pc (src_pc[0]),
        .mul_valid (src_valid[1]), .mul_value (src_value[1]), .mul_prf_idx (src_prf[1]),
        .mul_rob_idx (src_rob[1]), .mul_pc (src_pc[1]),
        .br_valid (src_valid[2]), .br_value (src_value[2]), .br_prf_idx (src_prf[2]),
        .br_rob_idx (src_rob[2]), .br_pc (src_pc[2]), .br_direction (br_direction),
        .br_target_pc (br_target_pc), .br_mis_pred (br_mis_pred),
        .br_local_pred (br_local_pred), .br_global_pred (br_global_pred),
        .dcache_valid (src_valid[3]), .dcache_value (src_value[3]),
        .dcache_prf_idx (src_prf[3]), .dcache_rob_idx (src_rob[3]), .dcache_pc (src_pc[3]),
        .sq_valid (src_valid[4]), .sq_value (src_value[4]), .sq_prf_idx (src_prf[4]),
        .sq_rob_idx (src_rob[4]), .sq_pc (src_pc[4]),
        .module_select (module_select), .cdb_valid (cdb_valid), .cdb_value (cdb_value),
        .cdb_prf_idx (cdb_prf_idx), .cdb_rob_idx (cdb_rob_idx), .cdb_pc (cdb_pc),
        .cdb_br_direction (cdb_br_direction), .cdb_br_target_pc (cdb_br_target_pc),
        .cdb_mis_pred (cdb_mis_pred), .cdb_local_pred (cdb_local_pred),
        .cdb_global_pred (cdb_global_pred)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [BW-1:0] input_entry(input int src);
        if (src == 2) begin
            return {src_value[2], src_prf[2], src_rob[2], src_pc[2], br_direction,
                    br_target_pc, br_mis_pred, br_local_pred, br_global_pred};
        end
        return {src_value[src], src_prf[src], src_rob[src], src_pc[src], 1'b0,
                `CDB_NO_TARGET, 3'b000};
    endfunction

    function automatic bit model_busy();
        for (int i = 0; i < 5; i++) begin
            if (model_q[i].size() != 0) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic int fault_total();
        return errors + timeouts + int'(DUT.checker_inst.failures);
    endfunction

    // mirror the coming edge while the bus is stable
    always @(negedge clock) begin
        logic [BW-1:0]       expected;
        logic [`XLEN-1:0]    e_value;
        logic [`PRF_LEN-1:0] e_prf;
        logic [`ROB_LEN-1:0] e_rob;
        logic [`XLEN-1:0]    e_pc;
        logic                e_dir;
        logic [`XLEN-1:0]    e_target;
        logic [2:0]          e_pred;
        int                  win;
        if (!rst_n) begin
            for (int i = 0; i < 5; i++) model_q[i].delete();
        end else begin
            for (int i = 0; i < 5; i++) begin
                if (src_valid[i]) begin
                    model_q[i].push_back(input_entry(i));
                    if (!commit_mis_pred) accepted++;
                end
            end
            win = -1;
            for (int i = 4; i >= 0; i--) begin
                if (model_q[i].size() != 0) win = i;
            end
            expected = (win < 0) ? IDLE_ENTRY : model_q[win][0];
            {e_value, e_prf, e_rob, e_pc, e_dir, e_target, e_pred} = expected;
            check_value("module_select", 32'((win < 0) ? SRC_NONE : cdb_src_e'(win + 1)),
                        32'(module_select));
            check_value("cdb_valid", 32'(win >= 0), 32'(cdb_valid));
            check_value("cdb_value", e_value, cdb_value);
            check_value("cdb_prf_idx", 32'(e_prf), 32'(cdb_prf_idx));
            check_value("cdb_rob_idx", 32'(e_rob), 32'(cdb_rob_idx));
            check_value("cdb_pc", e_pc, cdb_pc);
            check_value("cdb_br_direction", 32'(e_dir), 32'(cdb_br_direction));
            check_value("cdb_br_target_pc", e_target, cdb_br_target_pc);
            check_value("cdb_mis_pred", 32'(e_pred[2]), 32'(cdb_mis_pred));
            check_value("cdb_local_pred", 32'(e_pred[1]), 32'(cdb_local_pred));
            check_value("cdb_global_pred", 32'(e_pred[0]), 32'(cdb_global_pred));
            // count what the bus actually delivered
            if (cdb_valid === 1'b1) begin
                broadcasts++;
            end
            if (win >= 0) begin
                void'(model_q[win].pop_front());
            end
            if (commit_mis_pred) begin
                for (int i = 0; i < 5; i++) model_q[i].delete();
            end
        end
    end

    task automatic clear_inputs();
        for (int i = 0; i < 5; i++) begin
            src_valid[i] = 1'b0;
            src_value[i] = '0;
            src_prf[i] = '0;
            src_rob[i] = '0;
            src_pc[i] = '0;
        end
        {br_direction, br_mis_pred, br_local_pred, br_global_pred} = 4'b0000;
        br_target_pc = '0;
        commit_mis_pred = 1'b0;
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #1;
        clear_inputs();
    endtask

    task automatic set_result(input int src);
        logic [31:0] bits;
        bits = $urandom;
        src_valid[src] = 1'b1;
        src_value[src] = $urandom;
        src_prf[src] = bits[5:0];
        src_rob[src] = bits[10:6];
        src_pc[src] = $urandom & 32'hffff_fffc;
        if (src == 2) begin
            {br_direction, br_mis_pred, br_local_pred, br_global_pred} = bits[14:11];
            br_target_pc = $urandom & 32'hffff_fffc;
        end
    endtask

    task automatic wait_drain(input string what);
        int cycles;
        cycles = 0;
        while ((model_busy() || cdb_valid) && cycles < 50) begin
            next_cycle();
            cycles++;
        end
        if (model_busy() || cdb_valid) begin
            $display("timeout: %s did not drain within 50 cycles", what);
            timeouts++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (fault_total() == test_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d problems", tests_run, name, fault_total() - test_start);
        end
        test_start = fault_total();
    endtask

    initial begin
        void'($urandom(2095));
        clear_inputs();
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        rst_n = 1'b1;

        next_cycle();
        set_result(0);
        #1;
        check_value("module_select", 32'(SRC_ALU), 32'(module_select));
        next_cycle();
        wait_drain("bypass");
        finish_test("bypass");

        next_cycle();
        for (int i = 0; i < 5; i++) set_result(i);
        next_cycle();
        wait_drain("priority");
        finish_test("priority");

        // mul waits behind a continuous alu stream
        for (int c = 0; c < 6; c++) begin
            next_cycle();
            set_result(0);
            if (c < 3) set_result(1);
        end
        next_cycle();
        wait_drain("queueing order");
        finish_test("queueing order");

        for (int c = 0; c < 8; c++) begin
            next_cycle();
            if (c % 2 == 0) set_result(2);
            if (c % 3 == 0) set_result(0);
            if (c % 4 == 1) set_result(3);
        end
        next_cycle();
        wait_drain("branch fields");
        finish_test("branch fields");

        for (int c = 0; c < 2; c++) begin
            next_cycle();
            for (int i = 0; i < 5; i++) set_result(i);
        end
        next_cycle();
        commit_mis_pred = 1'b1;
        repeat (3) begin
            next_cycle();
            #1;
            check_value("cdb_valid", 32'(0), 32'(cdb_valid));
        end
        finish_test("flush");

        accepted = 0;
        broadcasts = 0;
        for (int c = 0; c < 80; c++) begin
            next_cycle();
            for (int i = 0; i < 5; i++) begin
                if ($urandom_range(3, 0) == 0 && model_q[i].size() < QDEPTH) set_result(i);
            end
        end
        next_cycle();
        wait_drain("random traffic");
        check_value("broadcast count", 32'(accepted), 32'(broadcasts));
        finish_test("random traffic");

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures, %0d timeouts",
                 tests_run, tests_failed, errors, DUT.checker_inst.failures, timeouts);
        if (tests_failed == 0 && fault_total() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
cdb_pkg.sv
result_queue.sv
cdb_arbiter.sv
cdb_broadcast_mux.sv
cdb.sv
cdb_checker.sv
cdb_tb.sv

//--- result_queue.sv
module result_queue #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 75
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             flush,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic             request,
    output logic [WIDTH-1:0] head_data,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             empty;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // an incoming result competes for the bus right away
    assign request = push | ~empty;

    // bypass when nothing is stored
    assign head_data = empty ? data_in : mem[head];

    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (pop) begin
                head <= next_ptr(head);
            end
            // push and pop together leave the occupancy unchanged
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload storage
    always_ff @(posedge clock) begin
        if (push) begin
            mem[tail] <= data_in;
        end
    end

endmodule
